// ==== include/fsx_consts.svh ====
// frame synthesizer constants
`ifndef FSX_CONSTS_SVH
`define FSX_CONSTS_SVH

// active area of the panel
`define FSX_H_RES           480
`define FSX_V_RES           272

// horizontal porches and sync, in clocks
`define FSX_H_FP            2
`define FSX_H_SYNC          41
`define FSX_H_BP            2

// vertical porches and sync, in lines
`define FSX_V_FP            2
`define FSX_V_SYNC          10
`define FSX_V_BP            2

// totals
`define FSX_LINE_CLKS       525
`define FSX_FRAME_LINES     286

// tile geometry
`define FSX_TILE            8
`define FSX_FETCH_LEAD      16      // two tiles ahead of the beam
`define FSX_TOP_SKIP        8       // black lines above the tiles
`define FSX_TILE_ROWS       32

// tile table strides, in entries per row
`define FSX_BG_STRIDE       64
`define FSX_WIN_STRIDE      60

// 8-bit port map
`define FSX_BG_TILE_BASE    0
`define FSX_BG_COLOR_BASE   2048
`define FSX_WIN_TILE_BASE   4096
`define FSX_WIN_COLOR_BASE  6144

// 32-bit port map with the patterns from address 0
`define FSX_PALETTE_BASE    1024

`define FSX_VRAM_AW         14

`endif

// ==== source/fsx_pkg.sv ====
// frame synthesizer types
`default_nettype none

`include "fsx_consts.svh"

package fsx_pkg;

    typedef logic [`FSX_VRAM_AW-1:0] vram_addr_t;

    // all zeros is black, or transparent in the window layer
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    // element 0 is the leftmost pixel
    typedef rgb332_t [7:0] tile_line_t;

    typedef enum logic [2:0] {
        PH_BG_TILE     = 3'd0,
        PH_BG_PATTERN  = 3'd1,
        PH_BG_COLOR    = 3'd2,
        PH_BG_PALETTE  = 3'd3,
        PH_WIN_TILE    = 3'd4,
        PH_WIN_PATTERN = 3'd5,
        PH_WIN_COLOR   = 3'd6,
        PH_WIN_PALETTE = 3'd7
    } fetch_phase_t;

    typedef struct packed {
        logic       hs;         // active low
        logic       vs;         // active low
        logic       de;
        logic [8:0] x;
        logic [8:0] y;
        logic       fetch_act;
        logic [8:0] fetch_x;    // x plus fetch lead
    } raster_t;

    typedef struct packed {
        logic    hs;
        logic    vs;
        logic    de;
        rgb332_t rgb;
    } video_out_t;

endpackage

`default_nettype wire

// ==== source/fsx_raster_timing.sv ====
// raster timing generator
`timescale 1ns/1ps
`default_nettype none

`include "fsx_consts.svh"

module fsx_raster_timing (
    input  logic             vga_clk,
    input  logic             i_rst_n,
    output fsx_pkg::raster_t o_raster
);

    localparam logic [9:0] HS_START    = 10'(`FSX_H_FP);
    localparam logic [9:0] HS_END      = 10'(`FSX_H_FP + `FSX_H_SYNC);
    localparam logic [9:0] HA_START    = 10'(`FSX_H_FP + `FSX_H_SYNC + `FSX_H_BP);
    localparam logic [9:0] HA_END      = HA_START + 10'(`FSX_H_RES);
    localparam logic [9:0] FETCH_START = HA_START - 10'(`FSX_FETCH_LEAD);
    localparam logic [9:0] FETCH_END   = FETCH_START + 10'(`FSX_H_RES);
    localparam logic [8:0] VS_START    = 9'(`FSX_V_FP);
    localparam logic [8:0] VS_END      = 9'(`FSX_V_FP + `FSX_V_SYNC);
    localparam logic [8:0] VA_START    = 9'(`FSX_V_FP + `FSX_V_SYNC + `FSX_V_BP);
    localparam logic [8:0] VA_END      = VA_START + 9'(`FSX_V_RES);

    logic [9:0] h_cnt;
    logic [8:0] v_cnt;
    logic       h_act;
    logic       v_act;
    logic       fetch_win;
    logic [9:0] h_rel;
    logic [9:0] f_rel;
    logic [8:0] v_rel;

    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == 10'(`FSX_LINE_CLKS - 1))
        begin
            h_cnt <= '0;
            if (v_cnt == 9'(`FSX_FRAME_LINES - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 9'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    assign h_act     = (h_cnt >= HA_START) && (h_cnt < HA_END);
    assign v_act     = (v_cnt >= VA_START) && (v_cnt < VA_END);
    assign fetch_win = (h_cnt >= FETCH_START) && (h_cnt < FETCH_END);

    assign h_rel = h_cnt - HA_START;
    assign f_rel = h_cnt - FETCH_START;    // free running so the phase keeps stepping
    assign v_rel = v_cnt - VA_START;

    always_comb
    begin
        o_raster.hs        = !((h_cnt >= HS_START) && (h_cnt < HS_END));
        o_raster.vs        = !((v_cnt >= VS_START) && (v_cnt < VS_END));
        o_raster.de        = h_act && v_act;
        o_raster.x         = (h_act && v_act) ? h_rel[8:0] : '0;
        o_raster.y         = v_act ? v_rel : '0;
        o_raster.fetch_act = fetch_win && v_act;
        o_raster.fetch_x   = f_rel[8:0];
    end

    a_cnt_range: assert property (@(posedge vga_clk) disable iff (!i_rst_n)
        (h_cnt < 10'(`FSX_LINE_CLKS)) && (v_cnt < 9'(`FSX_FRAME_LINES)));

endmodule

`default_nettype wire

// ==== source/fsx_tile_fetch.sv ====
// tile fetch sequencer
`timescale 1ns/1ps
`default_nettype none

`include "fsx_consts.svh"

module fsx_tile_fetch (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    input  fsx_pkg::raster_t    i_raster,
    output fsx_pkg::vram_addr_t o_vram8_addr,
    input  logic [7:0]          i_vram8_q,
    output fsx_pkg::vram_addr_t o_vram32_addr,
    input  logic [31:0]         i_vram32_q,
    output fsx_pkg::tile_line_t o_bg_line,
    output fsx_pkg::tile_line_t o_win_line
);

    import fsx_pkg::*;

    localparam vram_addr_t WIN_COLOR_END =
        vram_addr_t'(`FSX_WIN_COLOR_BASE + `FSX_TILE_ROWS * `FSX_WIN_STRIDE);

    fetch_phase_t phase;
    logic [7:0]   tile_y;
    logic [4:0]   tile_row;
    logic [2:0]   tile_line;
    logic [5:0]   tile_col;
    vram_addr_t   bg_ofs;
    vram_addr_t   win_ofs;
    vram_addr_t   pat_addr;
    vram_addr_t   pal_addr;
    logic [15:0]  pat_half;
    logic [15:0]  bg_pat;
    logic [15:0]  win_pat;
    logic [31:0]  bg_pal;
    tile_line_t   bg_stage;
    tile_line_t   win_stage;

    // 2-bit value v picks palette byte 3-v and pixel 0 takes the top bits
    function automatic tile_line_t resolve(input logic [15:0] pat, input logic [31:0] pal);
        tile_line_t res;
        logic [1:0] v;
        for (int k = 0; k < 8; k++)
        begin
            v      = pat[15 - 2*k -: 2];
            res[k] = pal[8*(3 - int'(v)) +: 8];
        end
        return res;
    endfunction

    assign phase     = fetch_phase_t'(i_raster.fetch_x[2:0]);
    assign tile_y    = 8'(i_raster.y - 9'(`FSX_TOP_SKIP));
    assign tile_row  = tile_y[7:3];
    assign tile_line = tile_y[2:0];
    assign tile_col  = i_raster.fetch_x[8:3];

    assign bg_ofs  = vram_addr_t'(tile_row) * vram_addr_t'(`FSX_BG_STRIDE)
                   + vram_addr_t'(tile_col);
    assign win_ofs = vram_addr_t'(tile_row) * vram_addr_t'(`FSX_WIN_STRIDE)
                   + vram_addr_t'(tile_col);

    // index read last cycle drives this cycle's 32-bit address
    assign pat_addr = vram_addr_t'({i_vram8_q, tile_line[2:1]});   // 4 words per tile
    assign pal_addr = vram_addr_t'(`FSX_PALETTE_BASE) + vram_addr_t'(i_vram8_q);

    assign pat_half = tile_line[0] ? i_vram32_q[15:0] : i_vram32_q[31:16];

    always_comb
    begin
        o_vram8_addr  = '0;
        o_vram32_addr = '0;
        if (i_raster.fetch_act)
        begin
            case (phase)
                PH_BG_TILE:     o_vram8_addr  = vram_addr_t'(`FSX_BG_TILE_BASE) + bg_ofs;
                PH_BG_PATTERN:  o_vram32_addr = pat_addr;
                PH_BG_COLOR:    o_vram8_addr  = vram_addr_t'(`FSX_BG_COLOR_BASE) + bg_ofs;
                PH_BG_PALETTE:  o_vram32_addr = pal_addr;
                PH_WIN_TILE:    o_vram8_addr  = vram_addr_t'(`FSX_WIN_TILE_BASE) + win_ofs;
                PH_WIN_PATTERN: o_vram32_addr = pat_addr;
                PH_WIN_COLOR:   o_vram8_addr  = vram_addr_t'(`FSX_WIN_COLOR_BASE) + win_ofs;
                PH_WIN_PALETTE: o_vram32_addr = pal_addr;
                default: ;
            endcase
        end
    end

    // each case branch sees the data for the address of the phase before
    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            bg_pat     <= '0;
            win_pat    <= '0;
            bg_pal     <= '0;
            bg_stage   <= '0;
            win_stage  <= '0;
            o_bg_line  <= '0;
            o_win_line <= '0;
        end
        else
        begin
            case (phase)
                PH_BG_COLOR:  bg_pat <= pat_half;
                PH_WIN_TILE:  bg_pal <= i_vram32_q;
                PH_WIN_COLOR: win_pat <= pat_half;
                PH_BG_TILE:
                begin
                    // window palette of the previous fetch tile is back
                    bg_stage  <= resolve(bg_pat, bg_pal);
                    win_stage <= resolve(win_pat, i_vram32_q);
                end
                PH_WIN_PALETTE:
                begin
                    // lands on the display tile boundary
                    o_bg_line  <= bg_stage;
                    o_win_line <= win_stage;
                end
                default: ;
            endcase
        end
    end

    a_vram8_range: assert property (@(posedge vga_clk) disable iff (!i_rst_n)
        i_raster.fetch_act |-> (o_vram8_addr < WIN_COLOR_END));

endmodule

`default_nettype wire

// ==== source/fsx_pixel_mixer.sv ====
// window and background pixel mixer
`timescale 1ns/1ps
`default_nettype none

`include "fsx_consts.svh"

module fsx_pixel_mixer (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    input  fsx_pkg::raster_t    i_raster,
    input  fsx_pkg::tile_line_t i_bg_line,
    input  fsx_pkg::tile_line_t i_win_line,
    output fsx_pkg::video_out_t o_video,
    output logic                o_frame_done
);

    import fsx_pkg::*;

    localparam logic [8:0] TILE_Y_START = 9'(`FSX_TOP_SKIP);
    localparam logic [8:0] TILE_Y_END   =
        9'(`FSX_TOP_SKIP + `FSX_TILE_ROWS * `FSX_TILE);

    logic [2:0] px_sel;
    rgb332_t    bg_px;
    rgb332_t    win_px;
    rgb332_t    mix_px;
    logic       in_tiles;
    logic       frame_hit;

    assign px_sel = i_raster.x[2:0];
    assign bg_px  = i_bg_line[px_sel];
    assign win_px = i_win_line[px_sel];
    assign mix_px = (win_px != '0) ? win_px : bg_px;   // zero is see-through

    assign in_tiles = (i_raster.y >= TILE_Y_START) && (i_raster.y < TILE_Y_END);

    // first pixel of the line just below the tiles
    assign frame_hit = i_raster.de && (i_raster.x == '0) && (i_raster.y == TILE_Y_END);

    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            o_video.hs   <= 1'b1;
            o_video.vs   <= 1'b1;
            o_video.de   <= 1'b0;
            o_video.rgb  <= '0;
            o_frame_done <= 1'b0;
        end
        else
        begin
            o_video.hs   <= i_raster.hs;
            o_video.vs   <= i_raster.vs;
            o_video.de   <= i_raster.de;
            o_video.rgb  <= (i_raster.de && in_tiles) ? mix_px : '0;
            o_frame_done <= frame_hit;
        end
    end

    a_blank_rgb: assert property (@(posedge vga_clk) disable iff (!i_rst_n)
        !o_video.de |-> (o_video.rgb == '0));

endmodule

`default_nettype wire

// ==== source/fsx_top.sv ====
// frame synthesizer top level
`timescale 1ns/1ps
`default_nettype none

module fsx_top (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    output fsx_pkg::vram_addr_t o_vram8_addr,
    input  logic [7:0]          i_vram8_q,
    output fsx_pkg::vram_addr_t o_vram32_addr,
    input  logic [31:0]         i_vram32_q,
    output fsx_pkg::video_out_t o_video,
    output logic                o_frame_done
);

    import fsx_pkg::*;

    raster_t    raster;
    tile_line_t bg_line;
    tile_line_t win_line;

    fsx_raster_timing raster_timing_i (
        .vga_clk  (vga_clk),
        .i_rst_n  (i_rst_n),
        .o_raster (raster)
    );

    // runs two tiles ahead of the mixer
    fsx_tile_fetch tile_fetch_i (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .i_raster      (raster),
        .o_vram8_addr  (o_vram8_addr),
        .i_vram8_q     (i_vram8_q),
        .o_vram32_addr (o_vram32_addr),
        .i_vram32_q    (i_vram32_q),
        .o_bg_line     (bg_line),
        .o_win_line    (win_line)
    );

    fsx_pixel_mixer pixel_mixer_i (
        .vga_clk      (vga_clk),
        .i_rst_n      (i_rst_n),
        .i_raster     (raster),
        .i_bg_line    (bg_line),
        .i_win_line   (win_line),
        .o_video      (o_video),
        .o_frame_done (o_frame_done)
    );

endmodule

`default_nettype wire

// ==== sim/tb_fsx.sv ====
// frame synthesizer testbench
`timescale 1ns/1ps
`default_nettype none

`include "fsx_consts.svh"

module tb_fsx;

    import fsx_pkg::*;

    typedef logic [8*24-1:0] token_t;

    localparam int FRAME_LIMIT = 2 * `FSX_LINE_CLKS * `FSX_FRAME_LINES;

    logic        vga_clk;
    logic        i_rst_n;
    vram_addr_t  vram8_addr;
    vram_addr_t  vram32_addr;
    logic [7:0]  vram8_q = '0;
    logic [31:0] vram32_q = '0;
    video_out_t  video;
    logic        frame_done;

    logic [7:0]  vram8  [0:(1 << `FSX_VRAM_AW) - 1] = '{default: '0};
    logic [31:0] vram32 [0:(1 << `FSX_VRAM_AW) - 1] = '{default: '0};
    rgb332_t     frame_buf [0:`FSX_H_RES * `FSX_V_RES - 1];

    string       px_name [$];
    int          px_x [$];
    int          px_y [$];
    rgb332_t     px_rgb [$];

    int          exp_line_clks;
    int          exp_hs_low;
    int          exp_de_clks;
    int          exp_de_lines;
    int          exp_vs_lines;
    int          exp_frame_clks;
    int          exp_done;

    fsx_top dut_i (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .o_vram8_addr  (vram8_addr),
        .i_vram8_q     (vram8_q),
        .o_vram32_addr (vram32_addr),
        .i_vram32_q    (vram32_q),
        .o_video       (video),
        .o_frame_done  (frame_done)
    );

    initial
    begin
        vga_clk = 1'b0;
        forever #2 vga_clk = ~vga_clk;
    end

    // both ports answer one cycle after the address
    always @(posedge vga_clk)
    begin
        vram8_q  <= vram8[vram8_addr];
        vram32_q <= vram32[vram32_addr];
    end

    task automatic end_in_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rgb(input string name, input rgb332_t exp_rgb, input rgb332_t act_rgb);
        if (act_rgb !== exp_rgb)
        begin
            $display("Error: %s expected 8'h%02h actual 8'h%02h", name, exp_rgb, act_rgb);
            end_in_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
        if (act_cnt != exp_cnt)
        begin
            $display("Error: %s expected %0d actual %0d", name, exp_cnt, act_cnt);
            end_in_failure();
        end
    endtask

    task automatic read_tests();
        int                fd;
        int                code;
        int                need;
        int                px;
        int                py;
        int                cnt;
        token_t            tok;
        string             kind;
        logic [8*128-1:0]  rest;
        logic [31:0]       addr;
        logic [31:0]       data;
        fd = $fopen("sim/fsx_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the test data file sim/fsx_tests.txt");
            end_in_failure();
        end
        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", tok);
            kind = string'(tok);
            if (code == 1)
            begin
                if (kind == "#")
                begin
                    code = $fgets(rest, fd);    // skip the comment text
                    need = code;
                end
                else if (kind == "w8" || kind == "w32")
                begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    need = 2;
                    if (kind == "w8")
                        vram8[addr[`FSX_VRAM_AW-1:0]] = data[7:0];
                    else
                        vram32[addr[`FSX_VRAM_AW-1:0]] = data;
                end
                else if (kind == "px")
                begin
                    code = $fscanf(fd, "%s %d %d %h", tok, px, py, data);
                    need = 4;
                    px_name.push_back(string'(tok));
                    px_x.push_back(px);
                    px_y.push_back(py);
                    px_rgb.push_back(rgb332_t'(data[7:0]));
                end
                else if (kind == "tm")
                begin
                    code = $fscanf(fd, "%s %d", tok, cnt);
                    need = 2;
                    case (string'(tok))
                        "line_clks":   exp_line_clks  = cnt;
                        "hs_low_clks": exp_hs_low     = cnt;
                        "de_clks":     exp_de_clks    = cnt;
                        "de_lines":    exp_de_lines   = cnt;
                        "vs_lines":    exp_vs_lines   = cnt;
                        "frame_clks":  exp_frame_clks = cnt;
                        "frame_done":  exp_done       = cnt;
                        default:       need = -1;
                    endcase
                end
                else
                begin
                    need = -1;
                end
                if (code != need)
                begin
                    $display("malformed or unknown record %s in the test data file", kind);
                    end_in_failure();
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_frame_start();
        int   cyc;
        logic prev_vs;
        logic found;
        cyc     = 0;
        prev_vs = 1'b0;
        found   = 1'b0;
        while (!found)
        begin
            @(negedge vga_clk);
            found   = prev_vs && !video.vs;
            prev_vs = video.vs;
            cyc++;
            if (!found && cyc > FRAME_LIMIT)
            begin
                $display("timeout waiting for the vertical sync to start");
                end_in_failure();
            end
        end
    endtask

    // one frame from a vs fall to the next
    task automatic measure_frame();
        video_out_t  prev;
        video_out_t  cur;
        logic [16:0] idx;
        logic        seen_hs;
        logic        found;
        int          cyc;
        int          since_hs;
        int          hs_low;
        int          col;
        int          line_y;
        int          vs_lines;
        int          dones;
        prev     = video;
        seen_hs  = 1'b0;
        found    = 1'b0;
        cyc      = 0;
        since_hs = 0;
        hs_low   = 0;
        col      = 0;
        line_y   = 0;
        vs_lines = 0;
        dones    = 0;
        while (!found)
        begin
            @(negedge vga_clk);
            cur = video;
            cyc++;
            since_hs++;
            if (frame_done)
                dones++;
            if (!cur.hs)
                hs_low++;
            // no fetch runs during the vertical sync
            if (!cur.vs)
            begin
                check_count("vsync_vram8_addr", 0, int'(vram8_addr));
                check_count("vsync_vram32_addr", 0, int'(vram32_addr));
            end
            if (prev.hs && !cur.hs)
            begin
                if (seen_hs)
                    check_count("line_clks", exp_line_clks, since_hs);
                seen_hs  = 1'b1;
                since_hs = 0;
                if (!cur.vs)
                    vs_lines++;
            end
            if (!prev.hs && cur.hs)
            begin
                check_count("hs_low_clks", exp_hs_low, hs_low);
                hs_low = 0;
            end
            if (cur.de && line_y < `FSX_V_RES && col < `FSX_H_RES)
            begin
                idx = 17'(line_y * `FSX_H_RES + col);
                frame_buf[idx] = cur.rgb;
            end
            if (cur.de)
                col++;
            if (prev.de && !cur.de)
            begin
                check_count("de_clks", exp_de_clks, col);
                col = 0;
                line_y++;
            end
            found = prev.vs && !cur.vs;
            prev  = cur;
            if (!found && cyc > FRAME_LIMIT)
            begin
                $display("timeout waiting for the end of the frame");
                end_in_failure();
            end
        end
        check_count("frame_clks", exp_frame_clks, cyc);
        check_count("de_lines", exp_de_lines, line_y);
        check_count("vs_lines", exp_vs_lines, vs_lines);
        check_count("frame_done", exp_done, dones);
    endtask

    task automatic check_pixels();
        logic [16:0] idx;
        for (int i = 0; i < px_name.size(); i++)
        begin
            idx = 17'(px_y[i] * `FSX_H_RES + px_x[i]);
            check_rgb(px_name[i], px_rgb[i], frame_buf[idx]);
        end
    endtask

    initial
    begin
        i_rst_n <= 1'b0;
        read_tests();
        repeat (2) @(posedge vga_clk);
        i_rst_n <= 1'b1;
        @(negedge vga_clk);
        check_count("reset_hs", 1, int'(video.hs));
        check_count("reset_vs", 1, int'(video.vs));
        check_count("reset_de", 0, int'(video.de));
        check_rgb("reset_rgb", '0, video.rgb);
        check_count("reset_frame_done", 0, int'(frame_done));
        check_count("reset_vram8_addr", 0, int'(vram8_addr));
        check_count("reset_vram32_addr", 0, int'(vram32_addr));
        wait_frame_start();
        measure_frame();
        check_pixels();
        measure_frame();    // second frame back to back
        check_pixels();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/fsx_tests.txt ====
# w8 and w32: addr data in hex, px: name x y rgb332 in hex
# tm: name and expected count in decimal
w8 0000 01
w8 0800 01
w32 0004 1be4ff00
w32 0401 e01c03ff
w8 0005 02
w8 0805 02
w32 0009 0000e41b
w32 0402 499224b6
w8 07fb 03
w8 0ffb 03
w32 000f 00005555
w32 0403 006d0000
w8 008a 04
w8 088a 04
w32 0404 92000000
w8 1082 05
w8 1882 05
w32 0014 1be40000
w32 0405 00003c1f
px bg_even_v0 0 8 e0
px bg_even_v1 1 8 1c
px bg_even_v2 2 8 03
px bg_even_v3 3 8 ff
px bg_even_k7 7 8 e0
px bg_odd_k0 0 9 ff
px bg_odd_k5 5 9 e0
px bg_col5_k0 40 11 b6
px bg_col5_k1 41 11 24
px bg_col5_k3 43 11 49
px bg_last_col 479 263 6d
px win_clear 80 24 92
px win_zero_byte 81 24 92
px win_v2 82 24 3c
px win_v3 83 24 1f
px win_k5 85 24 3c
px border_top 479 7 00
px border_bot_k0 0 264 00
px border_bot_col5 40 267 00
tm line_clks 525
tm hs_low_clks 41
tm de_clks 480
tm de_lines 272
tm vs_lines 10
tm frame_clks 150150
tm frame_done 1

// ==== files.f ====
+incdir+include
source/fsx_pkg.sv
source/fsx_raster_timing.sv
source/fsx_tile_fetch.sv
source/fsx_pixel_mixer.sv
source/fsx_top.sv
sim/tb_fsx.sv

// ==== Makefile ====
# Verilator build for the frame synthesizer testbench

VERILATOR ?= verilator
TOP       ?= tb_fsx
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
